/* src/rx_defs.svh */
/* receive chain parameters
   channel count, sample and timestamp widths, buffer depth, apb register map */

`ifndef RX_DEFS_SVH
`define RX_DEFS_SVH

//////////////////////////////
// datapath sizes
//////////////////////////////
`define RX_CHANNELS   2   // logical = physical channels
`define RX_SAMPLE_W   16  // bits per adc sample
`define RX_TSTAMP_W   16  // sample-count timestamp
`define RX_BUF_DEPTH  32  // entries, power of two

//////////////////////////////
// apb byte offsets
//////////////////////////////
`define RX_REG_CTRL     8'h00 // bit0 capture_en, bit1 clear
`define RX_REG_MUX      8'h04 // sel0 [1:0], sel1 [3:2]
`define RX_REG_THR0     8'h08
`define RX_REG_THR1     8'h0C
`define RX_REG_STATUS   8'h10 // count, overflow, empty
`define RX_REG_DATA_LO  8'h14 // head samples, no pop
`define RX_REG_DATA_HI  8'h18 // head mask/timestamp, pops

`endif

/* src/rx_pkg.sv */
/* shared types of the receive chain
   samples, timestamps, buffer entries and the apb register map */

`include "rx_defs.svh"

package rx_pkg;

  typedef logic signed [`RX_SAMPLE_W-1:0] sample_t;  // one adc sample
  typedef logic [`RX_TSTAMP_W-1:0] tstamp_t;         // valid-sample counter
  typedef logic [1:0] mux_sel_t;                     // 0 raw0, 1 raw1, 2 diff0, 3 diff1
  typedef logic [`RX_CHANNELS-1:0] chan_mask_t;      // threshold crossed per channel
  typedef logic [$clog2(`RX_BUF_DEPTH)-1:0] buf_ptr_t;
  typedef logic [$clog2(`RX_BUF_DEPTH):0] buf_count_t; // 0..depth inclusive
  typedef logic [7:0] apb_addr_t;

  // buffer word, timestamp on top, 50 bits in all
  typedef struct packed {
    tstamp_t    tstamp;
    chan_mask_t mask;
    sample_t    sample1;
    sample_t    sample0;
  } entry_t;

  typedef enum logic [7:0] {
    REG_CTRL    = `RX_REG_CTRL,
    REG_MUX     = `RX_REG_MUX,
    REG_THR0    = `RX_REG_THR0,
    REG_THR1    = `RX_REG_THR1,
    REG_STATUS  = `RX_REG_STATUS,
    REG_DATA_LO = `RX_REG_DATA_LO,
    REG_DATA_HI = `RX_REG_DATA_HI
  } reg_addr_e;

endpackage

/* src/rx_differentiator.sv */
/* first-difference stage
   per channel, current valid sample minus the previous one, raw passed alongside */

module rx_differentiator import rx_pkg::*; (
  input  logic    clk,
  input  logic    arst_n,
  input  sample_t adc_sample0,
  input  sample_t adc_sample1,
  input  logic    adc_valid,
  output sample_t raw0,
  output sample_t raw1,
  output sample_t diff0,
  output sample_t diff1,
  output logic    diff_valid
);

  sample_t prev0, prev1; // last valid sample per channel

  // history must start at 0 so the first difference is the sample itself
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      prev0      <= '0;
      prev1      <= '0;
      diff_valid <= 1'b0;
    end else begin
      diff_valid <= adc_valid; // one cycle latency
      if (adc_valid) begin
        prev0 <= adc_sample0;
        prev1 <= adc_sample1;
      end
    end
  end

  // payload, qualified by diff_valid downstream
  always_ff @(posedge clk) begin
    if (adc_valid) begin
      raw0  <= adc_sample0;
      raw1  <= adc_sample1;
      diff0 <= adc_sample0 - prev0; // wraps in sample width
      diff1 <= adc_sample1 - prev1;
    end
  end

endmodule

/* src/rx_channel_mux.sv */
/* channel mux
   builds two logical channels from raw and difference sources, registered */

module rx_channel_mux import rx_pkg::*; (
  input  logic     clk,
  input  logic     arst_n,
  input  sample_t  raw0,
  input  sample_t  raw1,
  input  sample_t  diff0,
  input  sample_t  diff1,
  input  logic     diff_valid,
  input  mux_sel_t mux_sel0,
  input  mux_sel_t mux_sel1,
  output sample_t  lch0,
  output sample_t  lch1,
  output logic     lch_valid
);

  sample_t pick0, pick1;

  // source index order matches the MUX register encoding
  function automatic sample_t pick_source(input mux_sel_t sel, input sample_t r0,
                                          input sample_t r1, input sample_t d0,
                                          input sample_t d1);
    sample_t s;
    case (sel)
      2'd0:    s = r0;
      2'd1:    s = r1;
      2'd2:    s = d0;
      default: s = d1;
    endcase
    return s;
  endfunction

  assign pick0 = pick_source(mux_sel0, raw0, raw1, diff0, diff1);
  assign pick1 = pick_source(mux_sel1, raw0, raw1, diff0, diff1);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) lch_valid <= 1'b0;
    else         lch_valid <= diff_valid; // second pipeline stage
  end

  always_ff @(posedge clk) begin
    lch0 <= pick0; // select applies from the cycle after the register write
    lch1 <= pick1;
  end

endmodule

/* src/rx_discriminator.sv */
/* threshold discriminator
   keeps samples whose magnitude exceeds the channel threshold, tags them with a timestamp */

module rx_discriminator import rx_pkg::*; (
  input  logic    clk,
  input  logic    arst_n,
  input  sample_t lch0,
  input  sample_t lch1,
  input  logic    lch_valid,
  input  sample_t thr0,       // unsigned magnitude threshold
  input  sample_t thr1,
  input  logic    capture_en,
  output entry_t  wr_entry,
  output logic    wr_en
);

  localparam sample_t SMAX = {1'b0, {($bits(sample_t)-1){1'b1}}}; // largest positive

  tstamp_t    tstamp;  // valid samples seen during capture
  sample_t    mag0, mag1;
  chan_mask_t mask;

  // |s|, the most negative value has no positive twin so it clips to SMAX
  function automatic sample_t magnitude(input sample_t s);
    sample_t m;
    m = s[$bits(sample_t)-1] ? -s : s;
    if (m[$bits(sample_t)-1]) m = SMAX; // still negative only for the minimum
    return m;
  endfunction

  assign mag0    = magnitude(lch0);
  assign mag1    = magnitude(lch1);
  assign mask[0] = $unsigned(mag0) > $unsigned(thr0); // strictly greater
  assign mask[1] = $unsigned(mag1) > $unsigned(thr1);

  //////////////////////////////
  // timestamp and write strobe
  //////////////////////////////
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      tstamp <= '0;
      wr_en  <= 1'b0;
    end else begin
      wr_en <= capture_en && lch_valid && (mask != '0);
      if (!capture_en)    tstamp <= '0;          // restart at 0 on next capture
      else if (lch_valid) tstamp <= tstamp + 1'b1; // kept or not, wraps
    end
  end

  // entry carries the count before this sample's increment
  always_ff @(posedge clk) begin
    if (lch_valid) begin
      wr_entry.tstamp  <= tstamp;
      wr_entry.mask    <= mask;
      wr_entry.sample1 <= lch1;
      wr_entry.sample0 <= lch0;
    end
  end

endmodule

/* src/rx_sample_buffer.sv */
/* sample buffer
   circular FIFO of captured entries, drops on full with a sticky overflow flag */

`include "rx_defs.svh"

module rx_sample_buffer import rx_pkg::*; (
  input  logic       clk,
  input  logic       arst_n,
  input  logic       wr_en,
  input  entry_t     wr_entry,
  input  logic       rd_pop,
  input  logic       buf_clear,
  output entry_t     rd_entry,  // head, meaningful when count != 0
  output buf_count_t count,
  output logic       overflow
);

  entry_t   mem [`RX_BUF_DEPTH];
  buf_ptr_t wr_ptr, rd_ptr;     // wrap naturally, depth is a power of two
  logic     full, empty;
  logic     do_push, do_pop;

  assign full    = (count == buf_count_t'(`RX_BUF_DEPTH));
  assign empty   = (count == '0);
  assign do_push = wr_en && !full;  // full check ignores a same-cycle pop
  assign do_pop  = rd_pop && !empty;

  assign rd_entry = mem[rd_ptr];

  //////////////////////////////
  // pointers, count, overflow
  //////////////////////////////
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      overflow <= 1'b0;
    end else if (buf_clear) begin // clear wins over push and pop
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      overflow <= 1'b0;
    end else begin
      if (do_push) wr_ptr <= wr_ptr + 1'b1;
      if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count; // none, or push and pop together
      endcase
      if (wr_en && full) overflow <= 1'b1; // sticky until clear
    end
  end

  // storage
  always_ff @(posedge clk) begin
    if (do_push && !buf_clear) mem[wr_ptr] <= wr_entry;
  end

endmodule

/* src/rx_apb_regs.sv */
/* apb register block
   configuration, status and pop-on-read readout of the sample buffer */

module rx_apb_regs import rx_pkg::*; (
  input  logic        clk,
  input  logic        arst_n,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  apb_addr_t   paddr,
  input  logic [31:0] pwdata,
  input  entry_t      rd_entry,
  input  buf_count_t  count,
  input  logic        overflow,
  output logic [31:0] prdata,
  output logic        pready,
  output logic        pslverr,
  output logic        capture_en,
  output logic        buf_clear,
  output mux_sel_t    mux_sel0,
  output mux_sel_t    mux_sel1,
  output sample_t     thr0,
  output sample_t     thr1,
  output logic        rd_pop
);

  reg_addr_e reg_addr;
  logic      access;   // access phase, completes this cycle
  logic      addr_hit;
  logic      empty;

  assign reg_addr = reg_addr_e'(paddr);
  assign access   = psel && penable;
  assign empty    = (count == '0);
  assign pready   = 1'b1; // no wait states

  //////////////////////////////
  // read mux and decode
  //////////////////////////////
  always_comb begin
    prdata   = '0;
    addr_hit = 1'b1;
    case (reg_addr)
      REG_CTRL:    prdata[0] = capture_en; // clear bit reads back 0
      REG_MUX:     prdata[3:0] = {mux_sel1, mux_sel0};
      REG_THR0:    prdata[15:0] = thr0;
      REG_THR1:    prdata[15:0] = thr1;
      REG_STATUS: begin
        prdata[$bits(buf_count_t)-1:0] = count;
        prdata[8] = overflow;
        prdata[9] = empty;
      end
      REG_DATA_LO: prdata = {rd_entry.sample1, rd_entry.sample0};
      REG_DATA_HI: prdata[17:0] = {rd_entry.mask, rd_entry.tstamp};
      default:     addr_hit = 1'b0;
    endcase
  end

  // error on unmapped offset, or reading an empty buffer's head
  assign pslverr = access && (!addr_hit || (!pwrite && reg_addr == REG_DATA_HI && empty));
  assign rd_pop  = access && !pwrite && reg_addr == REG_DATA_HI && !empty; // pops at cycle end

  //////////////////////////////
  // configuration writes
  //////////////////////////////
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      capture_en <= 1'b0;
      buf_clear  <= 1'b0;
      mux_sel0   <= '0; // raw 0 on both logical channels
      mux_sel1   <= '0;
      thr0       <= '0;
      thr1       <= '0;
    end else begin
      buf_clear <= 1'b0; // single-cycle pulse
      if (access && pwrite) begin
        case (reg_addr)
          REG_CTRL: begin
            capture_en <= pwdata[0];
            buf_clear  <= pwdata[1];
          end
          REG_MUX: begin
            mux_sel0 <= pwdata[1:0];
            mux_sel1 <= pwdata[3:2];
          end
          REG_THR0: thr0 <= pwdata[15:0];
          REG_THR1: thr1 <= pwdata[15:0];
          default:  ; // status and data are read only
        endcase
      end
    end
  end

endmodule

/* src/receive_top.sv */
/* receive chain top level
   adc samples through differentiator, mux and discriminator into the buffer, apb readout */

module receive_top import rx_pkg::*; (
  input  logic        clk,
  input  logic        arst_n,
  // adc side, no back-pressure
  input  sample_t     adc_sample0,
  input  sample_t     adc_sample1,
  input  logic        adc_valid,
  // apb slave
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  apb_addr_t   paddr,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        pready,
  output logic        pslverr
);

  sample_t    raw0, raw1, diff0, diff1;
  logic       diff_valid;
  sample_t    lch0, lch1;          // logical channels
  logic       lch_valid;
  mux_sel_t   mux_sel0, mux_sel1;
  sample_t    thr0, thr1;
  logic       capture_en, buf_clear;
  entry_t     wr_entry, rd_entry;
  logic       wr_en, rd_pop;
  buf_count_t count;
  logic       overflow;

  //////////////////////////////
  // producer
  //////////////////////////////
  rx_differentiator differentiator_i (
    .clk, .arst_n, .adc_sample0, .adc_sample1, .adc_valid,
    .raw0, .raw1, .diff0, .diff1, .diff_valid
  );

  rx_channel_mux channel_mux_i (
    .clk, .arst_n, .raw0, .raw1, .diff0, .diff1, .diff_valid,
    .mux_sel0, .mux_sel1, .lch0, .lch1, .lch_valid
  );

  rx_discriminator discriminator_i (
    .clk, .arst_n, .lch0, .lch1, .lch_valid, .thr0, .thr1, .capture_en,
    .wr_entry, .wr_en
  );

  // buffer
  rx_sample_buffer sample_buffer_i (
    .clk, .arst_n, .wr_en, .wr_entry, .rd_pop, .buf_clear,
    .rd_entry, .count, .overflow
  );

  // consumer
  rx_apb_regs apb_regs_i (
    .clk, .arst_n, .psel, .penable, .pwrite, .paddr, .pwdata,
    .rd_entry, .count, .overflow,
    .prdata, .pready, .pslverr, .capture_en, .buf_clear,
    .mux_sel0, .mux_sel1, .thr0, .thr1, .rd_pop
  );

endmodule

/* testbench/tb_clock_gen.sv */
/* testbench clock and reset
   period 10 clock, arst_n held low for the first 10 cycles */

module tb_clock_gen (
  output logic clk,
  output logic arst_n
);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    arst_n = 1'b0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1; // release away from the active edge
  end

endmodule

/* testbench/tb_receive_top.sv */
/* testbench for the receive chain
   random adc stimulus against a reference model, apb readout and checks */

`include "rx_defs.svh"

module tb_receive_top;

  localparam int TIMEOUT = 100; // max iterations of any wait loop

  // expected buffer word, same field order as the readout registers
  typedef struct packed {
    logic [15:0] ts;
    logic [1:0]  mask;
    logic [15:0] s1;
    logic [15:0] s0;
  } exp_entry_t;

  logic        clk, arst_n;
  logic [15:0] adc_sample0, adc_sample1;
  logic        adc_valid;
  logic        psel, penable, pwrite;
  logic [7:0]  paddr;
  logic [31:0] pwdata, prdata;
  logic        pready, pslverr;

  exp_entry_t  exp_q[$];        // entries the buffer should hold
  logic        exp_ovf;
  logic [15:0] prev0, prev1;    // last valid adc samples
  logic [1:0]  m_sel0, m_sel1;
  logic [15:0] m_thr0, m_thr1;
  logic        m_cap;
  logic [15:0] m_ts;
  logic [31:0] rng;
  int          checks, errors, tests, test_start;

  tb_clock_gen clock_gen_i (.clk, .arst_n);

  receive_top receive_top_inst (
    .clk, .arst_n, .adc_sample0, .adc_sample1, .adc_valid,
    .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready, .pslverr
  );

  //////////////////////////////
  // random numbers and model
  //////////////////////////////
  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_rand();
    rng = xorshift(rng);
    return rng;
  endfunction

  function automatic logic [15:0] rand_thr();
    logic [31:0] r;
    r = next_rand();
    return {2'b00, r[13:0]}; // at most a quarter of full scale
  endfunction

  // |s| with -32768 clipped to 32767
  function automatic int mag_of(input logic [15:0] s);
    int v;
    v = int'($signed(s));
    if (v < 0) v = -v;
    if (v > 32767) v = 32767;
    return v;
  endfunction

  task automatic model_sample(input logic [15:0] s0, input logic [15:0] s1);
    logic [15:0] src [4];
    exp_entry_t  e;
    src[0] = s0;
    src[1] = s1;
    src[2] = s0 - prev0; // 16 bit wrap
    src[3] = s1 - prev1;
    prev0  = s0;         // history moves with every valid sample
    prev1  = s1;
    e.s0   = src[m_sel0];
    e.s1   = src[m_sel1];
    e.mask = {mag_of(e.s1) > int'(m_thr1), mag_of(e.s0) > int'(m_thr0)};
    e.ts   = m_ts;
    if (m_cap) begin
      m_ts = m_ts + 16'd1; // counts kept and dropped alike
      if (e.mask != 2'b00) begin
        if (exp_q.size() < `RX_BUF_DEPTH) exp_q.push_back(e);
        else exp_ovf = 1'b1;
      end
    end
  endtask

  function automatic logic [31:0] exp_status();
    logic [5:0] cnt;
    cnt = 6'(exp_q.size());
    return {22'd0, (exp_q.size() == 0), exp_ovf, 2'b00, cnt};
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    checks++;
    assert (act === exp) else begin
      $display("** Error %s: expected 0x%08h, got 0x%08h", name, exp, act);
      errors++;
    end
  endtask

  //////////////////////////////
  // adc and apb drivers
  //////////////////////////////
  task automatic drive_sample(input logic [15:0] s0, input logic [15:0] s1, input int gap);
    adc_sample0 = s0;
    adc_sample1 = s1;
    adc_valid   = 1'b1;
    model_sample(s0, s1);
    @(negedge clk);
    adc_valid = 1'b0;
    repeat (gap) @(negedge clk); // idle cycles between samples
  endtask

  task automatic drive_random(input logic force_nonzero);
    logic [31:0] r, g;
    r = next_rand();
    g = next_rand();
    if (force_nonzero) r[0] = 1'b1;
    drive_sample(r[15:0], r[31:16], int'(g % 32'd3));
  endtask

  task automatic apb_transfer(input logic write, input logic [7:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
    int waits;
    psel    = 1'b1; // setup phase
    penable = 1'b0;
    pwrite  = write;
    paddr   = addr;
    pwdata  = wdata;
    @(negedge clk);
    penable = 1'b1;
    waits   = 0;
    #1;
    while (!pready && waits < TIMEOUT) begin
      @(negedge clk);
      #1;
      waits++;
    end
    assert (pready) else begin
      $display("timeout: pready never rose at offset 0x%02h", addr);
      errors++;
    end
    rdata = prdata; // stable until the closing edge
    err   = pslverr;
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_read(input logic [7:0] addr, output logic [31:0] rdata,
                          output logic err);
    apb_transfer(1'b0, addr, 32'd0, rdata, err);
  endtask

  task automatic apb_write(input logic [7:0] addr, input logic [31:0] wdata,
                           output logic err);
    logic [31:0] unused;
    apb_transfer(1'b1, addr, wdata, unused, err);
  endtask

  task automatic write_reg(input logic [7:0] addr, input logic [31:0] wdata);
    logic err;
    apb_write(addr, wdata, err);
    check_value("pslverr", 32'd0, {31'd0, err});
  endtask

  task automatic expect_read(input logic [7:0] addr, input string name,
                             input logic [31:0] exp_data, input logic exp_err);
    logic [31:0] rdata;
    logic        err;
    apb_read(addr, rdata, err);
    check_value("pslverr", {31'd0, exp_err}, {31'd0, err});
    if (!exp_err) check_value(name, exp_data, rdata);
  endtask

  //////////////////////////////
  // test steps
  //////////////////////////////
  task automatic configure(input logic [1:0] sel0, input logic [1:0] sel1,
                           input logic [15:0] thr0, input logic [15:0] thr1);
    write_reg(`RX_REG_MUX, {28'd0, sel1, sel0});
    write_reg(`RX_REG_THR0, {16'd0, thr0});
    write_reg(`RX_REG_THR1, {16'd0, thr1});
    m_sel0 = sel0;
    m_sel1 = sel1;
    m_thr0 = thr0;
    m_thr1 = thr1;
  endtask

  task automatic start_capture();
    write_reg(`RX_REG_CTRL, 32'h1);
    m_cap = 1'b1;
    m_ts  = 16'd0; // first sample of a capture is stamped 0
  endtask

  task automatic clear_buffer();
    write_reg(`RX_REG_CTRL, 32'h2); // capture off, clear pulse
    m_cap   = 1'b0;
    exp_ovf = 1'b0;
    exp_q.delete();
  endtask

  // wait until STATUS count agrees with the model
  task automatic settle_count();
    logic [31:0] rdata;
    logic        err;
    int          waits;
    waits = 0;
    apb_read(`RX_REG_STATUS, rdata, err);
    while (rdata[5:0] != 6'(exp_q.size()) && waits < TIMEOUT) begin
      apb_read(`RX_REG_STATUS, rdata, err);
      waits++;
    end
    assert (rdata[5:0] == 6'(exp_q.size())) else begin
      $display("timeout: buffer count stuck at %0d, model has %0d",
               rdata[5:0], exp_q.size());
      errors++;
    end
  endtask

  task automatic stop_capture();
    repeat (4) @(negedge clk); // drain the 3 stage pipeline, adc quiet
    write_reg(`RX_REG_CTRL, 32'h0);
    m_cap = 1'b0;
    settle_count();
    expect_read(`RX_REG_STATUS, "STATUS", exp_status(), 1'b0);
  endtask

  task automatic read_entries();
    exp_entry_t  e;
    logic [31:0] rdata;
    logic        err;
    while (exp_q.size() > 0) begin
      e = exp_q.pop_front();
      apb_read(`RX_REG_DATA_LO, rdata, err);
      check_value("DATA_LO", {e.s1, e.s0}, rdata);
      check_value("pslverr", 32'd0, {31'd0, err});
      apb_read(`RX_REG_DATA_HI, rdata, err); // pops the head
      check_value("DATA_HI", {14'd0, e.mask, e.ts}, rdata);
      check_value("pslverr", 32'd0, {31'd0, err});
    end
    expect_read(`RX_REG_STATUS, "STATUS", exp_status(), 1'b0);
  endtask

  task automatic end_test(input string name);
    tests++;
    $display("test %-24s %s", name, (errors == test_start) ? "passed" : "FAILED");
    test_start = errors;
  endtask

  //////////////////////////////
  // main sequence
  //////////////////////////////
  initial begin
    int waits;
    rng = 32'd34199;
    checks = 0;
    errors = 0;
    tests = 0;
    test_start = 0;
    adc_sample0 = '0;
    adc_sample1 = '0;
    adc_valid = 1'b0;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    prev0 = '0; // differentiator history after reset
    prev1 = '0;
    m_sel0 = '0;
    m_sel1 = '0;
    m_thr0 = '0;
    m_thr1 = '0;
    m_cap = 1'b0;
    m_ts = '0;
    exp_ovf = 1'b0;

    waits = 0;
    while (arst_n !== 1'b1 && waits < TIMEOUT) begin
      @(negedge clk);
      waits++;
    end
    assert (arst_n === 1'b1) else begin
      $display("timeout: reset was never released");
      errors++;
    end
    @(negedge clk);

    expect_read(`RX_REG_STATUS, "STATUS", 32'h0000_0200, 1'b0);
    expect_read(`RX_REG_CTRL, "CTRL", 32'h0, 1'b0);
    expect_read(`RX_REG_MUX, "MUX", 32'h0, 1'b0);
    end_test("reset state");

    // runs first so sample 0 is differenced against the reset history
    // lch0 threshold at full scale, a clipped -32768 must stay below it
    configure(2'd3, 2'd0, 16'h7FFF, rand_thr());
    start_capture();
    drive_sample(16'h8000, 16'h8000, 1); // most negative on both logical channels
    repeat (23) drive_random(1'b0);
    stop_capture();
    read_entries();
    end_test("difference, crossed mux");

    configure(2'd0, 2'd1, rand_thr(), rand_thr());
    start_capture();
    repeat (24) drive_random(1'b0);
    stop_capture();
    read_entries();
    end_test("raw capture");

    configure(2'd0, 2'd1, 16'd0, 16'd0); // every nonzero sample kept
    start_capture();
    repeat (40) drive_random(1'b1);
    stop_capture(); // count 32, overflow set
    read_entries();
    end_test("threshold zero, overflow");

    start_capture();
    repeat (6) drive_random(1'b1);
    stop_capture();
    clear_buffer();
    expect_read(`RX_REG_STATUS, "STATUS", exp_status(), 1'b0);
    expect_read(`RX_REG_DATA_HI, "DATA_HI", 32'h0, 1'b1); // empty head
    expect_read(8'h1C, "unmapped", 32'h0, 1'b1);
    start_capture();
    repeat (5) drive_random(1'b1);
    stop_capture();
    read_entries();
    end_test("clear and errors");

    $display("tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

/* verilog.f */
+incdir+src
src/rx_pkg.sv
src/rx_differentiator.sv
src/rx_channel_mux.sv
src/rx_discriminator.sv
src/rx_sample_buffer.sv
src/rx_apb_regs.sv
src/receive_top.sv
testbench/tb_clock_gen.sv
testbench/tb_receive_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the receive chain testbench with verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -f verilog.f --top-module tb_receive_top \
  --Mdir obj_dir -o tb_sim \
  && ./obj_dir/tb_sim | tee sim.log \
  && grep -qx "Everything OK" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
